//--- Bender.yml
package:
  name: snn_tile

sources:
  - hw/snn_pkg.sv
  - hw/packet_source.sv
  - hw/lif_array.sv
  - hw/network_sink.sv
  - hw/snn_top.sv
  - target: test
    files:
      - tests/snn_tb.sv

//--- hw/lif_array.sv
// integrate-and-fire neuron array without leak
// fire vector is combinational, charges update on each taken run or clear step
`timescale 1ns/1ps

module lif_array (
    input  logic                         clk,
    input  logic                         arstn,
    input  logic                         net_run,
    input  logic                         net_clear,
    input  logic                         net_ready,
    input  logic [snn_pkg::NUM_INP-1:0]  inp,
    output logic [snn_pkg::NUM_OUT-1:0]  net_out
);
    import snn_pkg::*;

    logic [NUM_OUT-1:0][CHARGE_WIDTH-1:0] charge;
    // one extra bit so the sum can exceed the charge range before saturation
    logic [NUM_OUT-1:0][CHARGE_WIDTH:0]   sum;

    always_comb begin
        for (int j = 0; j < NUM_OUT; j++) begin
            sum[j] = {1'b0, charge[j]};
            if (inp[j % NUM_INP]) begin
                sum[j] = sum[j] + (CHARGE_WIDTH + 1)'(W_SELF);
            end
            // neighbor input is the one just below, wrapping around
            if (inp[(j + NUM_INP - 1) % NUM_INP]) begin
                sum[j] = sum[j] + (CHARGE_WIDTH + 1)'(W_NEXT);
            end
            net_out[j] = (sum[j] >= (CHARGE_WIDTH + 1)'(THRESHOLD));
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            charge <= '0;
        end else if (net_ready) begin
            if (net_clear) begin
                charge <= '0;
            end else if (net_run) begin
                for (int j = 0; j < NUM_OUT; j++) begin
                    if (net_out[j]) begin
                        charge[j] <= '0;
                    end else if (sum[j][CHARGE_WIDTH]) begin
                        charge[j] <= '1;
                    end else begin
                        charge[j] <= sum[j][CHARGE_WIDTH-1:0];
                    end
                end
            end
        end
    end

    // the sink stalls the whole network by dropping net_ready
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!arstn)
        !net_ready |=> $stable(charge)
    );

endmodule

//--- hw/network_sink.sv
// SNN network sink
// turns run counts, clears, fired neurons and syncs into output packets
// with valid/ready back-pressure toward the network
`timescale 1ns/1ps

module network_sink (
    input  logic                           clk,
    input  logic                           arstn,
    input  logic                           net_run,
    input  logic                           net_sync,
    input  logic                           net_clear,
    output logic                           net_ready,
    input  logic [snn_pkg::NUM_OUT-1:0]    net_out,
    input  logic                           snk_ready,
    output logic                           snk_valid,
    output logic [snn_pkg::PKT_WIDTH-1:0]  snk
);
    import snn_pkg::*;

    typedef enum logic [2:0] {IDLE, RUNS, CLRD, SPKS, SYNC} state_t;

    state_t               curr_state;
    state_t               next_state;
    logic [RUN_WIDTH-1:0] run_counter;
    logic [RUN_WIDTH-1:0] runs;
    logic                 run_full;
    logic [NUM_OUT-1:0]   fires;
    logic [SPK_WIDTH-1:0] fire_counter;
    logic                 slot_done;
    logic                 sync_req;
    logic                 clear_req;
    logic                 take_run;
    logic                 take_clear;
    logic                 take_sync;
    logic                 take_event;

    assign run_full = &run_counter;

    // a full counter is flushed before any further command is taken
    assign net_ready = (curr_state == IDLE) && !run_full;

    assign take_run   = net_run && net_ready;
    assign take_clear = net_clear && net_ready;
    assign take_sync  = net_sync && net_ready;
    assign take_event = (take_run && |net_out) || take_clear || take_sync;

    // unfired slots pass in one cycle, fired ones wait for the handshake
    assign slot_done = !fires[fire_counter] || snk_ready;

    always_comb begin
        next_state = curr_state;
        case (curr_state)
            IDLE: begin
                if (run_full) begin
                    next_state = RUNS;
                end else if (take_event && run_counter != '0) begin
                    next_state = RUNS;
                end else if (take_clear) begin
                    next_state = CLRD;
                end else if (take_run && |net_out) begin
                    next_state = SPKS;
                end else if (take_sync) begin
                    next_state = SYNC;
                end
            end
            RUNS: begin
                if (snk_ready) begin
                    if (clear_req) begin
                        next_state = CLRD;
                    end else if (|fires) begin
                        next_state = SPKS;
                    end else if (sync_req) begin
                        next_state = SYNC;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            CLRD: begin
                if (snk_ready) begin
                    if (|fires) begin
                        next_state = SPKS;
                    end else if (sync_req) begin
                        next_state = SYNC;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            SPKS: begin
                if (slot_done && fire_counter == SPK_WIDTH'(NUM_OUT - 1)) begin
                    next_state = sync_req ? SYNC : IDLE;
                end
            end
            SYNC: begin
                if (snk_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            curr_state <= IDLE;
        end else begin
            curr_state <= next_state;
        end
    end

    // the taken step is counted, the RUN packet reports only the steps before it
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            run_counter <= '0;
            runs        <= '0;
        end else begin
            if (take_run) begin
                run_counter <= run_counter + 1'b1;
            end else if (curr_state == RUNS && next_state != RUNS) begin
                run_counter <= run_counter - runs;
            end
            if (curr_state == IDLE) begin
                runs <= run_counter;
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fires        <= '0;
            fire_counter <= '0;
        end else begin
            if (take_run) begin
                fires <= net_out;
            end else if (curr_state == SPKS && next_state != SPKS) begin
                fires <= '0;
            end
            // walks every slot in ascending order, wrapping back to zero at the end
            if (curr_state != SPKS) begin
                fire_counter <= '0;
            end else if (slot_done) begin
                fire_counter <= fire_counter + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            sync_req  <= 1'b0;
            clear_req <= 1'b0;
        end else begin
            if (take_sync) begin
                sync_req <= 1'b1;
            end else if (curr_state == SYNC && next_state != SYNC) begin
                sync_req <= 1'b0;
            end
            if (take_clear) begin
                clear_req <= 1'b1;
            end else if (curr_state == CLRD && next_state != CLRD) begin
                clear_req <= 1'b0;
            end
        end
    end

    always_comb begin
        snk       = '0;
        snk_valid = 1'b0;
        case (curr_state)
            RUNS: begin
                snk       = {RUN, runs};
                snk_valid = 1'b1;
            end
            CLRD: begin
                snk[PKT_WIDTH-1 -: OPC_WIDTH] = CLR;
                snk_valid = 1'b1;
            end
            SPKS: begin
                snk[PKT_WIDTH-1 -: OPC_WIDTH] = SPK;
                snk[RUN_WIDTH-1 -: SPK_WIDTH] = fire_counter;
                snk_valid = fires[fire_counter];
            end
            SYNC: begin
                snk[PKT_WIDTH-1 -: OPC_WIDTH] = SNC;
                snk_valid = 1'b1;
            end
            default: ;
        endcase
    end

    a_idle_silent: assert property (
        @(posedge clk) disable iff (!arstn)
        curr_state == IDLE |-> !snk_valid
    );

    a_snk_stable: assert property (
        @(posedge clk) disable iff (!arstn)
        snk_valid && !snk_ready |=> snk_valid && $stable(snk)
    );

endmodule

//--- hw/packet_source.sv
// SNN packet source
// decodes input packets into run, clear and sync commands and pending input spikes
`timescale 1ns/1ps

module packet_source (
    input  logic                           clk,
    input  logic                           arstn,
    input  logic                           src_valid,
    input  logic [snn_pkg::PKT_WIDTH-1:0]  src,
    output logic                           src_ready,
    output logic                           net_run,
    output logic                           net_clear,
    output logic                           net_sync,
    input  logic                           net_ready,
    output logic [snn_pkg::NUM_INP-1:0]    inp
);
    import snn_pkg::*;

    logic                 accept;
    logic                 take;
    logic [OPC_WIDTH-1:0] opc;
    logic [RUN_WIDTH-1:0] payload;
    logic [IDX_WIDTH-1:0] spk_idx;
    logic [RUN_WIDTH-1:0] run_left;

    assign opc     = src[PKT_WIDTH-1 -: OPC_WIDTH];
    assign payload = src[RUN_WIDTH-1:0];
    assign spk_idx = src[RUN_WIDTH-1 -: IDX_WIDTH];

    // no new packet while a command waits for the network
    assign src_ready = !(net_run || net_clear || net_sync);
    assign accept    = src_valid && src_ready;
    assign take      = net_ready && (net_run || net_clear || net_sync);

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            net_run   <= 1'b0;
            net_clear <= 1'b0;
            net_sync  <= 1'b0;
            run_left  <= '0;
        end else if (accept) begin
            case (opc)
                RUN: begin
                    // a zero step count issues nothing
                    if (payload != '0) begin
                        net_run  <= 1'b1;
                        run_left <= payload;
                    end
                end
                CLR: net_clear <= 1'b1;
                SNC: net_sync  <= 1'b1;
                default: ;
            endcase
        end else if (take) begin
            net_clear <= 1'b0;
            net_sync  <= 1'b0;
            if (net_run) begin
                run_left <= run_left - 1'b1;
                if (run_left == RUN_WIDTH'(1)) begin
                    net_run <= 1'b0;
                end
            end
        end
    end

    // input spikes only apply to the first step of a run
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            inp <= '0;
        end else if (accept && opc == SPK) begin
            inp[spk_idx] <= 1'b1;
        end else if (net_run && net_ready) begin
            inp <= '0;
        end
    end

    a_one_command: assert property (
        @(posedge clk) disable iff (!arstn)
        $onehot0({net_run, net_clear, net_sync})
    );

endmodule

//--- hw/snn_pkg.sv
// SNN tile shared definitions
// packet format, opcodes, neuron counts, weights and firing threshold
package snn_pkg;

    // the opcode sits in the top bits with the payload below
    localparam int PKT_WIDTH = 8;
    localparam int OPC_WIDTH = 2;
    localparam int RUN_WIDTH = PKT_WIDTH - OPC_WIDTH;

    // opcodes
    localparam logic [OPC_WIDTH-1:0] RUN = 2'd0;
    localparam logic [OPC_WIDTH-1:0] CLR = 2'd1;
    localparam logic [OPC_WIDTH-1:0] SPK = 2'd2;
    localparam logic [OPC_WIDTH-1:0] SNC = 2'd3;

    // network shape
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 4;

    // neuron index fields, placed at the top of the payload
    localparam int IDX_WIDTH = $clog2(NUM_INP);
    // a single output neuron would make this zero and the index implicit
    localparam int SPK_WIDTH = $clog2(NUM_OUT);

    // neuron model
    localparam int CHARGE_WIDTH = 4;
    localparam int THRESHOLD = 3;

    // input i feeds output i and output (i+1) mod NUM_OUT through fixed synapses
    localparam int W_SELF = 2;
    localparam int W_NEXT = 1;

endpackage

//--- hw/snn_top.sv
// SNN processor tile
// packet source feeds the neuron array, network sink packs its fire vector
`timescale 1ns/1ps

module snn_top (
    input  logic                           clk,
    input  logic                           arstn,
    input  logic                           src_valid,
    input  logic [snn_pkg::PKT_WIDTH-1:0]  src,
    output logic                           src_ready,
    input  logic                           snk_ready,
    output logic                           snk_valid,
    output logic [snn_pkg::PKT_WIDTH-1:0]  snk
);
    import snn_pkg::*;

    logic               net_run;
    logic               net_clear;
    logic               net_sync;
    logic               net_ready;
    logic [NUM_INP-1:0] inp;
    logic [NUM_OUT-1:0] net_out;

    packet_source u_source (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src       (src),
        .src_ready (src_ready),
        .net_run   (net_run),
        .net_clear (net_clear),
        .net_sync  (net_sync),
        .net_ready (net_ready),
        .inp       (inp)
    );

    lif_array u_array (
        .clk       (clk),
        .arstn     (arstn),
        .net_run   (net_run),
        .net_clear (net_clear),
        .net_ready (net_ready),
        .inp       (inp),
        .net_out   (net_out)
    );

    network_sink u_sink (
        .clk       (clk),
        .arstn     (arstn),
        .net_run   (net_run),
        .net_sync  (net_sync),
        .net_clear (net_clear),
        .net_ready (net_ready),
        .net_out   (net_out),
        .snk_ready (snk_ready),
        .snk_valid (snk_valid),
        .snk       (snk)
    );

endmodule

//--- tests/snn_patterns.txt
// tag nibble then packet: 1xx input, 2xx expected output, 3nn start of test nn, 000 end
// packet bytes: 00+n RUN n, 40 CLR, 80/90/A0/B0 SPK 0..3, C0 SNC
301
180
1B0
101 // input 0 and 3 give output 0 a sum of 3
1C0
280
201
2C0
302
105
190
101
205 // silent steps come out before the spike
290
303
180
1A0
1B0
101
201
280
2A0
2B0
304
103
140
190
101 // output 1 stays below threshold since the clear
1C0
1C0
204
240
201
2C0
2C0
305
13F
103
1C0
23F
203
2C0
000

//--- tests/snn_tb.sv
// SNN tile testbench
// plays input packets from the pattern file and checks the output packet stream
// while the sink side stalls at random
`timescale 1ns/1ps

module snn_tb;
    import snn_pkg::*;

    localparam int MAX_WORDS        = 128;
    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int DRAIN_CYCLES     = 20;
    localparam int RNG_SEED         = 11604;

    logic                 clk;
    logic                 arstn;
    logic                 src_valid;
    logic [PKT_WIDTH-1:0] src;
    logic                 src_ready;
    logic                 snk_ready;
    logic                 snk_valid;
    logic [PKT_WIDTH-1:0] snk;

    logic [11:0]          patterns [MAX_WORDS];
    logic [PKT_WIDTH-1:0] inputs[$];
    logic [PKT_WIDTH-1:0] expected[$];
    int                   expected_test[$];
    int                   num_entries;
    int                   cycle_count;
    int                   cycle_limit;
    int                   mismatches;
    int                   other_errors;
    int                   received;

    snn_top UUT (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src       (src),
        .src_ready (src_ready),
        .snk_ready (snk_ready),
        .snk_valid (snk_valid),
        .snk       (snk)
    );

    always #50 clk = ~clk;

    function automatic string test_name(input int id);
        case (id)
            1: return "spike_fire";
            2: return "silent_runs";
            3: return "multi_fire";
            4: return "clear_sync";
            5: return "saturation";
            default: return "unnamed";
        endcase
    endfunction

    // top nibble 1 is an input, 2 an expected output, 3 a new test, 0 the end
    task automatic load_patterns();
        int i;
        int section;
        section = 0;
        for (i = 0; i < MAX_WORDS; i++) begin
            patterns[i] = '0;
        end
        $readmemh("tests/snn_patterns.txt", patterns);
        i = 0;
        while (i < MAX_WORDS && patterns[i][11:8] != 4'h0) begin
            case (patterns[i][11:8])
                4'h1: inputs.push_back(patterns[i][7:0]);
                4'h2: begin
                    expected.push_back(patterns[i][7:0]);
                    expected_test.push_back(section);
                end
                4'h3: section = patterns[i][7:0];
                default: begin
                    $display("pattern word %0d has an unknown tag: %03h", i, patterns[i]);
                    other_errors++;
                end
            endcase
            i++;
        end
        num_entries = i;
        if (inputs.size() == 0 || expected.size() == 0) begin
            $display("the pattern file held no input or no expected packets");
            other_errors++;
        end
    endtask

    task automatic check_output(input logic [PKT_WIDTH-1:0] pkt);
        logic [PKT_WIDTH-1:0] want;
        int                   id;
        received++;
        if (expected.size() == 0) begin
            $display("output packet %02h arrived after the expected list ran out", pkt);
            other_errors++;
        end else begin
            want = expected.pop_front();
            id   = expected_test.pop_front();
            if (pkt !== want) begin
                $display("ERROR test %s expected %02h actual %02h", test_name(id), want, pkt);
                mismatches++;
            end
        end
    endtask

    task automatic print_counts();
        $display("checked %0d output packets: %0d mismatches, %0d other errors",
                 received, mismatches, other_errors);
    endtask

    // inputs go out in file order, each held until the source takes it
    task automatic play_inputs();
        for (int k = 0; k < inputs.size(); k++) begin
            src       = inputs[k];
            src_valid = 1'b1;
            while (!src_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        src_valid = 1'b0;
        src       = '0;
    endtask

    // snk_ready is drawn on the falling edge, so valid, ready and snk seen here
    // are exactly what the next rising edge will use
    initial begin
        logic [PKT_WIDTH-1:0] held;
        bit                   stalled;
        held      = '0;
        stalled   = 1'b0;
        snk_ready = 1'b0;
        void'($urandom(RNG_SEED));
        forever begin
            @(negedge clk);
            snk_ready = ($urandom % 100) < 70;
            if (arstn && stalled && (!snk_valid || snk !== held)) begin
                $display("output packet %02h changed or vanished while stalled", held);
                other_errors++;
            end
            if (arstn && snk_valid && snk_ready) begin
                check_output(snk);
            end
            stalled = snk_valid && !snk_ready;
            held    = snk;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run stopped after %0d cycles with %0d output packets still missing",
                     cycle_count, expected.size());
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arstn        = 1'b0;
        src_valid    = 1'b0;
        src          = '0;
        mismatches   = 0;
        other_errors = 0;
        received     = 0;
        cycle_count  = 0;
        num_entries  = 0;
        load_patterns();
        cycle_limit = RESET_CYCLES + CYCLES_PER_ENTRY * num_entries;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        if (src_ready !== 1'b1 || snk_valid !== 1'b0) begin
            $display("after reset the source is not ready or the sink is not silent");
            other_errors++;
        end
        play_inputs();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // idle cycles so that a packet beyond the expected list gets caught
        repeat (DRAIN_CYCLES) @(negedge clk);
        print_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/snn_pkg.sv
hw/packet_source.sv
hw/lif_array.sv
hw/network_sink.sv
hw/snn_top.sv
tests/snn_tb.sv
